// File: source/rv_pkg.sv
// ========================================
// Shared types and encodings for the RV64
// pipeline. Only the opcodes the core
// executes are defined here
// ========================================
package rv_pkg;

   typedef logic [63:0] xlen_t;
   typedef logic [31:0] instr_t;
   typedef logic [4:0]  reg_addr_t;

   // Major opcodes in bits 6:0
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   // addi x0, x0, 0
   localparam instr_t NOP_INSTR = 32'h0000_0013;

   typedef enum logic [1:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR
   } alu_op_e;

   // Operand sources seen by execute
   typedef enum logic [1:0] {
      FWD_REG,
      FWD_MEM,
      FWD_WB
   } fwd_sel_e;

endpackage

// File: source/fetch_unit.sv
// ========================================
// Program counter and instruction memory
// PC advances by 4 only with enable high
// and no stall. Load the memory while
// enable is low
// ========================================
`timescale 1ns/1ps

module fetch_unit import rv_pkg::*; #(
   parameter int IMEM_ADDR_W = 9
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   enable,
   input  logic                   stall,
   input  logic [IMEM_ADDR_W-1:0] ext_addr,
   input  logic                   ext_wen,
   input  instr_t                 ext_wdata,
   output instr_t                 instr,
   output xlen_t                  pc
);

   instr_t imem [2**IMEM_ADDR_W];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc <= '0;
      end else if (enable && !stall) begin
         pc <= pc + xlen_t'(4);
      end
   end

   // Written only through the loader port
   always_ff @(posedge clk) begin
      if (ext_wen) begin
         imem[ext_addr] <= ext_wdata;
      end
   end

   // Word index from the PC and higher bits wrap
   assign instr = imem[pc[IMEM_ADDR_W+1:2]];

endmodule

// File: source/decode_unit.sv
// ========================================
// Control decode for add/sub/and/or, addi,
// ld and sd. Unknown opcodes decode with
// every control bit low
// ========================================
`timescale 1ns/1ps

module decode_unit import rv_pkg::*; (
   input  instr_t    instr,
   output reg_addr_t rs1,
   output reg_addr_t rs2,
   output reg_addr_t rd,
   output xlen_t     imm,
   output alu_op_e   alu_op,
   output logic      alu_src,
   output logic      mem_read,
   output logic      mem_write,
   output logic      mem_to_reg,
   output logic      reg_write
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       funct7_alt;

   assign opcode     = instr[6:0];
   assign funct3     = instr[14:12];
   assign funct7_alt = instr[30];

   assign rs1 = instr[19:15];
   assign rd  = instr[11:7];

   // Only R-type and stores read rs2
   // Masking it keeps addi and ld from causing false load-use stalls
   assign rs2 = (opcode == OPC_OP || opcode == OPC_STORE) ? instr[24:20] : '0;

   // S-type immediate is split around the rd field
   assign imm = (opcode == OPC_STORE) ?
                {{52{instr[31]}}, instr[31:25], instr[11:7]} :
                {{52{instr[31]}}, instr[31:20]};

   always_comb begin
      alu_src    = 1'b0;
      mem_read   = 1'b0;
      mem_write  = 1'b0;
      mem_to_reg = 1'b0;
      reg_write  = 1'b0;
      case (opcode)
         OPC_OP: begin
            reg_write = 1'b1;
         end
         OPC_OP_IMM: begin
            alu_src   = 1'b1;
            reg_write = 1'b1;
         end
         OPC_LOAD: begin
            alu_src    = 1'b1;
            mem_read   = 1'b1;
            mem_to_reg = 1'b1;
            reg_write  = 1'b1;
         end
         OPC_STORE: begin
            alu_src   = 1'b1;
            mem_write = 1'b1;
         end
         default: ;
      endcase
   end

   // Address generation for ld and sd falls to add
   always_comb begin
      alu_op = ALU_ADD;
      if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
         case (funct3)
            // Bit 30 means sub for R-type only
            3'b000:  alu_op = (opcode == OPC_OP && funct7_alt) ? ALU_SUB : ALU_ADD;
            3'b110:  alu_op = ALU_OR;
            3'b111:  alu_op = ALU_AND;
            default: alu_op = ALU_ADD;
         endcase
      end
   end

endmodule

// File: source/register_file.sv
// ========================================
// 32 x 64-bit register file with x0
// reading 0. Reads are write-through
// ========================================
`timescale 1ns/1ps

module register_file import rv_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      reg_write,
   input  reg_addr_t raddr_1,
   input  reg_addr_t raddr_2,
   input  reg_addr_t waddr,
   input  xlen_t     wdata,
   output xlen_t     rdata_1,
   output xlen_t     rdata_2
);

   xlen_t regs [1:31];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (reg_write && waddr != '0) begin
         regs[waddr] <= wdata;
      end
   end

   // Same-cycle writeback is visible to decode
   function automatic xlen_t read_port(reg_addr_t raddr);
      xlen_t value;
      if (raddr == '0) begin
         value = '0;
      end else if (reg_write && raddr == waddr) begin
         value = wdata;
      end else begin
         value = regs[raddr];
      end
      return value;
   endfunction

   always_comb begin
      rdata_1 = read_port(raddr_1);
      rdata_2 = read_port(raddr_2);
   end

endmodule

// File: source/hazard_unit.sv
// ========================================
// Load-use stall and operand forwarding
// EX/MEM has priority over MEM/WB
// ========================================
`timescale 1ns/1ps

module hazard_unit import rv_pkg::*; (
   input  reg_addr_t id_rs1,
   input  reg_addr_t id_rs2,
   input  reg_addr_t ex_rd,
   input  logic      ex_mem_read,
   input  reg_addr_t ex_rs1,
   input  reg_addr_t ex_rs2,
   input  reg_addr_t mem_rd,
   input  logic      mem_reg_write,
   input  reg_addr_t wb_rd,
   input  logic      wb_reg_write,
   output logic      stall,
   output fwd_sel_e  fwd_a,
   output fwd_sel_e  fwd_b
);

   // Load in execute whose result decode needs next cycle
   assign stall = ex_mem_read && ex_rd != '0 &&
                  (ex_rd == id_rs1 || ex_rd == id_rs2);

   function automatic fwd_sel_e pick_source(reg_addr_t rs);
      fwd_sel_e sel;
      if (mem_reg_write && mem_rd != '0 && mem_rd == rs) begin
         sel = FWD_MEM;
      end else if (wb_reg_write && wb_rd != '0 && wb_rd == rs) begin
         sel = FWD_WB;
      end else begin
         sel = FWD_REG;
      end
      return sel;
   endfunction

   always_comb begin
      fwd_a = pick_source(ex_rs1);
      fwd_b = pick_source(ex_rs2);
   end

endmodule

// File: source/execute_unit.sv
// ========================================
// Forwarding muxes, operand select and ALU
// Arithmetic wraps modulo 2^64
// ========================================
`timescale 1ns/1ps

module execute_unit import rv_pkg::*; (
   input  xlen_t    rdata_1,
   input  xlen_t    rdata_2,
   input  xlen_t    imm,
   input  xlen_t    mem_result,
   input  xlen_t    wb_result,
   input  fwd_sel_e fwd_a,
   input  fwd_sel_e fwd_b,
   input  logic     alu_src,
   input  alu_op_e  alu_op,
   output xlen_t    alu_result,
   output xlen_t    store_data
);

   xlen_t operand_a;
   xlen_t operand_b;

   function automatic xlen_t fwd_mux(fwd_sel_e sel, xlen_t reg_value,
                                     xlen_t mem_value, xlen_t wb_value);
      xlen_t value;
      case (sel)
         FWD_MEM: value = mem_value;
         FWD_WB:  value = wb_value;
         default: value = reg_value;
      endcase
      return value;
   endfunction

   always_comb begin
      operand_a  = fwd_mux(fwd_a, rdata_1, mem_result, wb_result);
      // sd needs the forwarded rs2 even though the ALU takes imm
      store_data = fwd_mux(fwd_b, rdata_2, mem_result, wb_result);
      operand_b  = alu_src ? imm : store_data;
      case (alu_op)
         ALU_SUB: alu_result = operand_a - operand_b;
         ALU_AND: alu_result = operand_a & operand_b;
         ALU_OR:  alu_result = operand_a | operand_b;
         default: alu_result = operand_a + operand_b;
      endcase
   end

endmodule

// File: source/data_memory.sv
// ========================================
// Doubleword data memory with two ports
// Pipeline side uses byte addresses and
// ignores bits 2:0. No arbitration. The
// external write wins on a collision
// ========================================
`timescale 1ns/1ps

module data_memory import rv_pkg::*; #(
   parameter int DMEM_ADDR_W = 10
) (
   input  logic                   clk,
   input  xlen_t                  addr,
   input  logic                   mem_write,
   input  xlen_t                  wdata,
   output xlen_t                  rdata,
   input  logic [DMEM_ADDR_W-1:0] ext_addr,
   input  logic                   ext_wen,
   input  xlen_t                  ext_wdata,
   output xlen_t                  ext_rdata
);

   xlen_t                  mem [2**DMEM_ADDR_W];
   logic [DMEM_ADDR_W-1:0] word_addr;

   // Byte address divided by 8
   assign word_addr = addr[DMEM_ADDR_W+2:3];

   always_ff @(posedge clk) begin
      if (mem_write) begin
         mem[word_addr] <= wdata;
      end
      if (ext_wen) begin
         mem[ext_addr] <= ext_wdata;
      end
   end

   assign rdata     = mem[word_addr];
   assign ext_rdata = mem[ext_addr];

endmodule

// File: source/cpu.sv
// ========================================
// Five-stage RV64 subset pipeline without
// branches. Pipeline runs only while
// enable is high. Use the memory ports
// only with enable low
// ========================================
`timescale 1ns/1ps

module cpu import rv_pkg::*; #(
   parameter int IMEM_ADDR_W = 9,
   parameter int DMEM_ADDR_W = 10
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   enable,
   input  logic [IMEM_ADDR_W-1:0] imem_addr,
   input  logic                   imem_wen,
   input  instr_t                 imem_wdata,
   input  logic [DMEM_ADDR_W-1:0] dmem_addr,
   input  logic                   dmem_wen,
   input  xlen_t                  dmem_wdata,
   output xlen_t                  dmem_rdata
);

   instr_t    fetch_instr;
   instr_t    if_id_instr;

   reg_addr_t id_rs1, id_rs2, id_rd;
   xlen_t     id_imm, id_rdata_1, id_rdata_2;
   alu_op_e   id_alu_op;
   logic      id_alu_src, id_mem_read, id_mem_write, id_mem_to_reg, id_reg_write;
   logic      stall;

   logic      id_ex_reg_write, id_ex_mem_read, id_ex_mem_write, id_ex_mem_to_reg;
   logic      id_ex_alu_src;
   alu_op_e   id_ex_alu_op;
   xlen_t     id_ex_rdata_1, id_ex_rdata_2, id_ex_imm;
   reg_addr_t id_ex_rs1, id_ex_rs2, id_ex_rd;

   fwd_sel_e  fwd_a, fwd_b;
   xlen_t     ex_alu_result, ex_store_data;

   logic      ex_mem_reg_write, ex_mem_mem_write, ex_mem_mem_to_reg;
   xlen_t     ex_mem_alu_result, ex_mem_store_data;
   reg_addr_t ex_mem_rd;
   xlen_t     mem_load_data;

   logic      mem_wb_reg_write, mem_wb_mem_to_reg;
   xlen_t     mem_wb_load_data, mem_wb_alu_result;
   reg_addr_t mem_wb_rd;
   xlen_t     wb_result;

   // Fetch
   fetch_unit #(
      .IMEM_ADDR_W(IMEM_ADDR_W)
   ) u_fetch (
      .clk       (clk),
      .rst_n     (rst_n),
      .enable    (enable),
      .stall     (stall),
      .ext_addr  (imem_addr),
      .ext_wen   (imem_wen),
      .ext_wdata (imem_wdata),
      .instr     (fetch_instr),
      // Nothing downstream needs the PC without branches
      .pc        ()
   );

   // Held on a stall so the dependent instruction is decoded again
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         if_id_instr <= NOP_INSTR;
      end else if (enable && !stall) begin
         if_id_instr <= fetch_instr;
      end
   end

   // Decode
   decode_unit u_decode (
      .instr      (if_id_instr),
      .rs1        (id_rs1),
      .rs2        (id_rs2),
      .rd         (id_rd),
      .imm        (id_imm),
      .alu_op     (id_alu_op),
      .alu_src    (id_alu_src),
      .mem_read   (id_mem_read),
      .mem_write  (id_mem_write),
      .mem_to_reg (id_mem_to_reg),
      .reg_write  (id_reg_write)
   );

   register_file u_regfile (
      .clk       (clk),
      .rst_n     (rst_n),
      .reg_write (mem_wb_reg_write & enable),
      .raddr_1   (id_rs1),
      .raddr_2   (id_rs2),
      .waddr     (mem_wb_rd),
      .wdata     (wb_result),
      .rdata_1   (id_rdata_1),
      .rdata_2   (id_rdata_2)
   );

   hazard_unit u_hazard (
      .id_rs1        (id_rs1),
      .id_rs2        (id_rs2),
      .ex_rd         (id_ex_rd),
      .ex_mem_read   (id_ex_mem_read),
      .ex_rs1        (id_ex_rs1),
      .ex_rs2        (id_ex_rs2),
      .mem_rd        (ex_mem_rd),
      .mem_reg_write (ex_mem_reg_write),
      .wb_rd         (mem_wb_rd),
      .wb_reg_write  (mem_wb_reg_write),
      .stall         (stall),
      .fwd_a         (fwd_a),
      .fwd_b         (fwd_b)
   );

   // Stall turns the ID/EX slot into a bubble
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         id_ex_reg_write  <= 1'b0;
         id_ex_mem_read   <= 1'b0;
         id_ex_mem_write  <= 1'b0;
         id_ex_mem_to_reg <= 1'b0;
      end else if (enable) begin
         id_ex_reg_write  <= id_reg_write & ~stall;
         id_ex_mem_read   <= id_mem_read & ~stall;
         id_ex_mem_write  <= id_mem_write & ~stall;
         id_ex_mem_to_reg <= id_mem_to_reg & ~stall;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         id_ex_alu_src <= id_alu_src;
         id_ex_alu_op  <= id_alu_op;
         id_ex_rdata_1 <= id_rdata_1;
         id_ex_rdata_2 <= id_rdata_2;
         id_ex_imm     <= id_imm;
         id_ex_rs1     <= id_rs1;
         id_ex_rs2     <= id_rs2;
         id_ex_rd      <= id_rd;
      end
   end

   // Execute
   execute_unit u_execute (
      .rdata_1    (id_ex_rdata_1),
      .rdata_2    (id_ex_rdata_2),
      .imm        (id_ex_imm),
      .mem_result (ex_mem_alu_result),
      .wb_result  (wb_result),
      .fwd_a      (fwd_a),
      .fwd_b      (fwd_b),
      .alu_src    (id_ex_alu_src),
      .alu_op     (id_ex_alu_op),
      .alu_result (ex_alu_result),
      .store_data (ex_store_data)
   );

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_mem_reg_write  <= 1'b0;
         ex_mem_mem_write  <= 1'b0;
         ex_mem_mem_to_reg <= 1'b0;
      end else if (enable) begin
         ex_mem_reg_write  <= id_ex_reg_write;
         ex_mem_mem_write  <= id_ex_mem_write;
         ex_mem_mem_to_reg <= id_ex_mem_to_reg;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         ex_mem_alu_result <= ex_alu_result;
         ex_mem_store_data <= ex_store_data;
         ex_mem_rd         <= id_ex_rd;
      end
   end

   // Memory
   // Gated so a frozen store does not write again
   data_memory #(
      .DMEM_ADDR_W(DMEM_ADDR_W)
   ) u_dmem (
      .clk       (clk),
      .addr      (ex_mem_alu_result),
      .mem_write (ex_mem_mem_write & enable),
      .wdata     (ex_mem_store_data),
      .rdata     (mem_load_data),
      .ext_addr  (dmem_addr),
      .ext_wen   (dmem_wen),
      .ext_wdata (dmem_wdata),
      .ext_rdata (dmem_rdata)
   );

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mem_wb_reg_write  <= 1'b0;
         mem_wb_mem_to_reg <= 1'b0;
      end else if (enable) begin
         mem_wb_reg_write  <= ex_mem_reg_write;
         mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         mem_wb_load_data  <= mem_load_data;
         mem_wb_alu_result <= ex_mem_alu_result;
         mem_wb_rd         <= ex_mem_rd;
      end
   end

   // Writeback
   assign wb_result = mem_wb_mem_to_reg ? mem_wb_load_data : mem_wb_alu_result;

endmodule

// File: verification/cpu_tb.sv
// ========================================
// Testbench for the cpu pipeline. Loads a
// fixed program and random operands with
// enable low, runs, then reads results
// 2 to 9 back over the dmem port
// ========================================
`timescale 1ns/1ps

module cpu_tb import rv_pkg::*;;

   localparam int IMEM_AW     = 9;
   localparam int DMEM_AW     = 10;
   localparam int ROUNDS      = 8;
   localparam int PROG_LEN    = 21;
   localparam int PROG_WORDS  = 48;
   localparam int RUN_CYCLES  = PROG_LEN + 12;
   localparam int FREEZE_AT   = 9;
   localparam int FREEZE_LEN  = 5;
   localparam int FIRST_SLOT  = 2;
   localparam int LAST_SLOT   = 9;
   localparam int MAX_CYCLES  = ROUNDS * (PROG_WORDS + RUN_CYCLES + 30);

   logic               clk;
   logic               rst_n;
   logic               enable;
   logic [IMEM_AW-1:0] imem_addr;
   logic               imem_wen;
   instr_t             imem_wdata;
   logic [DMEM_AW-1:0] dmem_addr;
   logic               dmem_wen;
   xlen_t              dmem_wdata;
   xlen_t              dmem_rdata;

   instr_t      program_words [PROG_WORDS];
   logic [31:0] lfsr_state  = 32'd86;
   int          error_count = 0;
   int          check_count = 0;
   int          cycle_count = 0;

   // Results waiting for the compare process
   int    round_q[$];
   int    slot_q[$];
   xlen_t a_q[$];
   xlen_t b_q[$];
   xlen_t actual_q[$];
   event  results_ready;

   cpu #(
      .IMEM_ADDR_W(IMEM_AW),
      .DMEM_ADDR_W(DMEM_AW)
   ) DUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .enable     (enable),
      .imem_addr  (imem_addr),
      .imem_wen   (imem_wen),
      .imem_wdata (imem_wdata),
      .dmem_addr  (dmem_addr),
      .dmem_wen   (dmem_wen),
      .dmem_wdata (dmem_wdata),
      .dmem_rdata (dmem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Test FAILED");
         $finish;
      end
   end

   // Instruction encoders
   function automatic instr_t enc_r(logic [6:0] funct7, logic [2:0] funct3,
                                    reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
      return {funct7, rs2, rs1, funct3, rd, OPC_OP};
   endfunction

   function automatic instr_t enc_addi(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
      return {imm, rs1, 3'b000, rd, OPC_OP_IMM};
   endfunction

   function automatic instr_t enc_ld(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
      return {imm, rs1, 3'b011, rd, OPC_LOAD};
   endfunction

   function automatic instr_t enc_sd(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], OPC_STORE};
   endfunction

   // Expected slot contents from the ISA rules modulo 2^64
   function automatic xlen_t expected_result(int slot, xlen_t a, xlen_t b);
      xlen_t sum;
      xlen_t diff;
      xlen_t masked;
      xlen_t merged;
      sum    = a + b;
      diff   = sum - a;
      masked = diff & b;
      merged = masked | sum;
      case (slot)
         2:       return sum;
         3:       return diff;
         4:       return masked;
         5:       return merged;
         6:       return merged - 64'd5;
         8:       return a + a;
         9:       return b;
         default: return '0;
      endcase
   endfunction

   function automatic logic [31:0] lfsr_step(logic [31:0] state);
      logic [31:0] next;
      next = state >> 1;
      if (state[0]) begin
         next = next ^ 32'hA300_0000;
      end
      return next;
   endfunction

   // One LFSR step per bit
   task automatic draw_xlen(output xlen_t value);
      value = '0;
      for (int i = 0; i < 64; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         value = {value[62:0], lfsr_state[0]};
      end
   endtask

   task automatic check_xlen(string name, xlen_t expected, xlen_t actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic build_program();
      for (int i = 0; i < PROG_WORDS; i++) begin
         program_words[i] = NOP_INSTR;
      end
      program_words[0]  = enc_ld(5'd1, 5'd0, 12'd0);
      program_words[1]  = enc_ld(5'd2, 5'd0, 12'd8);
      // Load-use on x2 while x1 is written back
      program_words[2]  = enc_r(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2);
      program_words[3]  = enc_r(7'b0100000, 3'b000, 5'd4, 5'd3, 5'd1);
      program_words[4]  = enc_r(7'b0000000, 3'b111, 5'd5, 5'd4, 5'd2);
      program_words[5]  = enc_r(7'b0000000, 3'b110, 5'd6, 5'd5, 5'd3);
      program_words[6]  = enc_addi(5'd7, 5'd6, -12'sd5);
      program_words[7]  = enc_r(7'b0000000, 3'b000, 5'd0, 5'd1, 5'd2);
      for (int r = 3; r <= 7; r++) begin
         program_words[r + 5] = enc_sd(5'(r), 5'd0, 12'(8 * (r - 1)));
      end
      program_words[13] = enc_sd(5'd0, 5'd0, 12'd56);
      program_words[14] = enc_ld(5'd1, 5'd0, 12'd0);
      program_words[15] = enc_r(7'b0000000, 3'b000, 5'd8, 5'd1, 5'd1);
      program_words[16] = enc_sd(5'd8, 5'd0, 12'd64);
      program_words[20] = enc_sd(5'd2, 5'd0, 12'd72);
   endtask

   task automatic write_imem(int addr, instr_t word);
      @(posedge clk);
      #1;
      imem_addr  = IMEM_AW'(addr);
      imem_wdata = word;
      imem_wen   = 1'b1;
   endtask

   task automatic write_dmem(int addr, xlen_t value);
      @(posedge clk);
      #1;
      dmem_addr  = DMEM_AW'(addr);
      dmem_wdata = value;
      dmem_wen   = 1'b1;
   endtask

   // Lets the last pending write land, then drops the strobes
   task automatic finish_writes();
      @(posedge clk);
      #1;
      imem_wen = 1'b0;
      dmem_wen = 1'b0;
   endtask

   task automatic read_dmem(int addr, output xlen_t value);
      @(posedge clk);
      #1;
      dmem_addr = DMEM_AW'(addr);
      @(negedge clk);
      value = dmem_rdata;
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #1;
      rst_n = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
   endtask

   task automatic run_program(bit freeze);
      @(posedge clk);
      #1;
      enable = 1'b1;
      if (freeze) begin
         repeat (FREEZE_AT) @(posedge clk);
         #1;
         enable = 1'b0;
         repeat (FREEZE_LEN) @(posedge clk);
         #1;
         enable = 1'b1;
         repeat (RUN_CYCLES - FREEZE_AT) @(posedge clk);
      end else begin
         repeat (RUN_CYCLES) @(posedge clk);
      end
      #1;
      enable = 1'b0;
   endtask

   // Compare process
   initial begin
      string name;
      forever begin
         @(results_ready);
         while (actual_q.size() > 0) begin
            name = $sformatf("round %0d slot %0d", round_q[0], slot_q[0]);
            check_xlen(name, expected_result(slot_q[0], a_q[0], b_q[0]), actual_q[0]);
            void'(round_q.pop_front());
            void'(slot_q.pop_front());
            void'(a_q.pop_front());
            void'(b_q.pop_front());
            void'(actual_q.pop_front());
         end
      end
   end

   initial begin
      xlen_t op_a;
      xlen_t op_b;
      xlen_t value;
      rst_n      = 1'b0;
      enable     = 1'b0;
      imem_addr  = '0;
      imem_wen   = 1'b0;
      imem_wdata = '0;
      dmem_addr  = '0;
      dmem_wen   = 1'b0;
      dmem_wdata = '0;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      build_program();
      for (int round = 0; round < ROUNDS; round++) begin
         draw_xlen(op_a);
         draw_xlen(op_b);
         for (int i = 0; i < PROG_WORDS; i++) begin
            write_imem(i, program_words[i]);
         end
         finish_writes();
         write_dmem(0, op_a);
         write_dmem(1, op_b);
         finish_writes();
         apply_reset();
         // Odd rounds pause the pipeline mid-program
         run_program(round % 2 == 1);
         for (int slot = FIRST_SLOT; slot <= LAST_SLOT; slot++) begin
            read_dmem(slot, value);
            round_q.push_back(round);
            slot_q.push_back(slot);
            a_q.push_back(op_a);
            b_q.push_back(op_b);
            actual_q.push_back(value);
         end
         -> results_ready;
      end
      @(posedge clk);
      $display("Summary: %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0 && check_count == ROUNDS * (LAST_SLOT - FIRST_SLOT + 1)) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// File: riscv_pipe.f
source/rv_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/register_file.sv
source/hazard_unit.sv
source/execute_unit.sv
source/data_memory.sv
source/cpu.sv
verification/cpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the cpu_tb simulation with Verilator, run it and scan the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module cpu_tb -f riscv_pipe.f -o cpu_tb_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/cpu_tb_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
   exit 1
fi
exit 0
